// ==== hdl/led_panel_pkg.sv ====
`default_nettype none

package led_panel_pkg;

	// one store from the bus, strobe high for a single cycle
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
		logic        strobe;
	} bus_wr_t;

	typedef logic [3:0] pixel_t; // colour bits for one half, one column

	// timing registers to scan controller
	typedef struct packed {
		logic [15:0] blank_cycles;
		logic        enable;
	} scan_cfg_t;

	// address map, upper 16 address bits
	localparam logic [15:0] FB_REGION = 16'h0002;
	localparam logic [15:0] CTRL_REGION = 16'h0003;

	// word offsets inside CTRL_REGION
	localparam int BLANK_REG_WORD = 0;
	localparam int ENABLE_REG_WORD = 1;

	// panel geometry, two halves of ROWS rows each
	localparam int DEFAULT_COLUMNS = 64;
	localparam int DEFAULT_ROWS = 32;
	localparam int DEFAULT_BLANK = 8; // oe-low cycles per row

endpackage

`default_nettype wire

// ==== hdl/frame_store.sv ====
`default_nettype none

module frame_store #(
	parameter int COLUMNS = led_panel_pkg::DEFAULT_COLUMNS,
	parameter int ROWS = led_panel_pkg::DEFAULT_ROWS
) (
	input wire clk,
	input wire rst,
	input wire led_panel_pkg::bus_wr_t bus,
	input wire fbuf_re,
	input wire [$clog2(ROWS)-1:0] row_addr,
	input wire [$clog2(COLUMNS)-1:0] col_addr,
	output led_panel_pkg::pixel_t dout_a,
	output led_panel_pkg::pixel_t dout_b
);

	localparam int ROW_W = $clog2(ROWS);
	localparam int COL_W = $clog2(COLUMNS);
	localparam int IDX_W = 1 + ROW_W + COL_W; // half, row, column
	localparam int DEPTH = 2 * ROWS * COLUMNS;

	led_panel_pkg::pixel_t mem [DEPTH];

	logic fb_sel;
	logic fb_we;
	logic [IDX_W-1:0] wr_idx;
	logic [IDX_W-1:0] rd_idx_a;
	logic [IDX_W-1:0] rd_idx_b;

	// region decode on the upper address half
	assign fb_sel = (bus.addr[31:16] == led_panel_pkg::FB_REGION);
	assign fb_we = bus.strobe && fb_sel;

	// word index sits right above the byte offset
	assign wr_idx = bus.addr[IDX_W+1:2];

	// bit IDX_W-1 picks the half of the panel
	assign rd_idx_a = {1'b0, row_addr, col_addr}; // upper half
	assign rd_idx_b = {1'b1, row_addr, col_addr}; // lower half

	// blank frame at power-up, block ram init value
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	always @(posedge clk) begin
		if (fb_we) begin
			mem[wr_idx] <= bus.data[3:0]; // only the low nibble is a pixel
		end
	end

	// both read ports registered, one cycle after fbuf_re
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			dout_a <= '0;
			dout_b <= '0;
		end else if (fbuf_re) begin
			dout_a <= mem[rd_idx_a];
			dout_b <= mem[rd_idx_b];
		end
	end

endmodule

`default_nettype wire

// ==== hdl/scan_timing_regs.sv ====
`default_nettype none

module scan_timing_regs #(
	parameter int BLANK_RESET = led_panel_pkg::DEFAULT_BLANK
) (
	input wire clk,
	input wire rst,
	input wire led_panel_pkg::bus_wr_t bus,
	output led_panel_pkg::scan_cfg_t scan_cfg
);

	logic ctrl_sel;
	logic [13:0] word_off;
	logic blank_we;
	logic enable_we;
	logic [15:0] blank_q;
	logic enable_q;

	assign ctrl_sel = bus.strobe && (bus.addr[31:16] == led_panel_pkg::CTRL_REGION);
	assign word_off = bus.addr[15:2];

	assign blank_we = ctrl_sel && (word_off == 14'(led_panel_pkg::BLANK_REG_WORD));
	assign enable_we = ctrl_sel && (word_off == 14'(led_panel_pkg::ENABLE_REG_WORD));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			blank_q <= 16'(BLANK_RESET);
			enable_q <= 1'b1; // scan runs out of reset
		end else begin
			// zero blanking would keep the row dark, so it is refused
			if (blank_we && (bus.data[15:0] != 16'd0)) begin
				blank_q <= bus.data[15:0];
			end
			if (enable_we) begin
				enable_q <= bus.data[0];
			end
		end
	end

	assign scan_cfg.blank_cycles = blank_q;
	assign scan_cfg.enable = enable_q;

	// a blanking store, zero or not, leaves a usable length behind
	assert property (@(posedge clk) disable iff (rst)
		blank_we |=> (scan_cfg.blank_cycles != 16'd0))
	else $error("blank_cycles left at zero after store");

endmodule

`default_nettype wire

// ==== hdl/scan_ctrl.sv ====
`default_nettype none

module scan_ctrl #(
	parameter int COLUMNS = led_panel_pkg::DEFAULT_COLUMNS,
	parameter int ROWS = led_panel_pkg::DEFAULT_ROWS
) (
	input wire clk,
	input wire rst,
	input wire led_panel_pkg::scan_cfg_t scan_cfg,
	output logic [$clog2(ROWS)-1:0] row_addr,
	output logic [$clog2(COLUMNS)-1:0] col_addr,
	output logic fbuf_re,
	output logic display_oe,
	output logic latch,
	output logic display_clk
);

	localparam int ROW_W = $clog2(ROWS);
	localparam int COL_W = $clog2(COLUMNS);

	typedef enum logic [2:0] {
		IDLE,     // waiting before column 0
		FETCH,    // cycle 1, read request
		SHIFT_HI, // cycle 2, panel clock high
		SHIFT_LO, // cycle 3, column advances
		LATCH_HI,
		LATCH_LO, // row advances
		BLANK
	} state_t;

	state_t state;
	state_t state_nxt;

	logic [15:0] blank_cnt;
	logic last_col;
	logic last_row;
	logic blank_done;

	assign last_col = (col_addr == COL_W'(COLUMNS - 1));
	assign last_row = (row_addr == ROW_W'(ROWS - 1));
	assign blank_done = (blank_cnt <= 16'd1);

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (scan_cfg.enable) begin
					state_nxt = FETCH;
				end
			end
			FETCH: state_nxt = SHIFT_HI;
			SHIFT_HI: state_nxt = SHIFT_LO;
			SHIFT_LO: begin
				if (last_col) begin
					state_nxt = LATCH_HI;
				end else begin
					state_nxt = FETCH;
				end
			end
			LATCH_HI: state_nxt = LATCH_LO;
			LATCH_LO: state_nxt = BLANK;
			BLANK: begin
				// enable only matters at the start of a row
				if (blank_done) begin
					state_nxt = scan_cfg.enable ? FETCH : IDLE;
				end
			end
			default: state_nxt = IDLE;
		endcase
	end

	// panel strobes are registered copies of the next state
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= IDLE;
			row_addr <= '0;
			col_addr <= '0;
			blank_cnt <= '0;
			fbuf_re <= 1'b0;
			display_clk <= 1'b0;
			latch <= 1'b0;
			display_oe <= 1'b1; // active low, panel dark
		end else begin
			state <= state_nxt;
			fbuf_re <= (state_nxt == FETCH);
			display_clk <= (state_nxt == SHIFT_HI);
			latch <= (state_nxt == LATCH_HI);
			display_oe <= (state_nxt != BLANK);

			if (state == SHIFT_LO) begin
				col_addr <= last_col ? '0 : col_addr + 1'b1;
			end

			if (state == LATCH_LO) begin
				row_addr <= last_row ? '0 : row_addr + 1'b1;
			end

			// length taken once per row, as blanking starts
			if (state == LATCH_LO) begin
				blank_cnt <= scan_cfg.blank_cycles;
			end else if (state == BLANK) begin
				blank_cnt <= blank_cnt - 1'b1;
			end
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		!(latch && display_clk))
	else $error("latch and display_clk high together");

	// oe only drops while the row is blanked
	assert property (@(posedge clk) disable iff (rst)
		!display_oe |-> (state == BLANK))
	else $error("display_oe low outside blanking");

	assert property (@(posedge clk) disable iff (rst)
		fbuf_re |-> (state == FETCH))
	else $error("fbuf_re high outside fetch");

endmodule

`default_nettype wire

// ==== hdl/led_panel_top.sv ====
`default_nettype none

module led_panel_top #(
	parameter int COLUMNS = led_panel_pkg::DEFAULT_COLUMNS,
	parameter int ROWS = led_panel_pkg::DEFAULT_ROWS,
	parameter int BLANK_RESET = led_panel_pkg::DEFAULT_BLANK
) (
	input wire clk,
	input wire rst,
	input wire led_panel_pkg::bus_wr_t bus,
	output logic [$clog2(ROWS)-1:0] row_addr,
	output logic [$clog2(COLUMNS)-1:0] col_addr,
	output logic display_oe,
	output logic latch,
	output logic display_clk,
	output led_panel_pkg::pixel_t dout_a,
	output led_panel_pkg::pixel_t dout_b
);

	logic fbuf_re;
	led_panel_pkg::scan_cfg_t scan_cfg;

	// pixel memory, both halves in one array
	frame_store #(
		.COLUMNS(COLUMNS),
		.ROWS(ROWS)
	) u_frame_store (
		.clk(clk),
		.rst(rst),
		.bus(bus),
		.fbuf_re(fbuf_re),
		.row_addr(row_addr),
		.col_addr(col_addr),
		.dout_a(dout_a),
		.dout_b(dout_b)
	);

	scan_timing_regs #(
		.BLANK_RESET(BLANK_RESET)
	) u_scan_timing_regs (
		.clk(clk),
		.rst(rst),
		.bus(bus),
		.scan_cfg(scan_cfg)
	);

	scan_ctrl #(
		.COLUMNS(COLUMNS),
		.ROWS(ROWS)
	) u_scan_ctrl (
		.clk(clk),
		.rst(rst),
		.scan_cfg(scan_cfg),
		.row_addr(row_addr),
		.col_addr(col_addr),
		.fbuf_re(fbuf_re),
		.display_oe(display_oe),
		.latch(latch),
		.display_clk(display_clk)
	);

endmodule

`default_nettype wire

// ==== bench/panel_monitor.sv ====
`default_nettype none

module panel_monitor #(
	parameter int COLUMNS = led_panel_pkg::DEFAULT_COLUMNS,
	parameter int ROWS = led_panel_pkg::DEFAULT_ROWS,
	parameter int BLANK_RESET = led_panel_pkg::DEFAULT_BLANK
) (
	input wire clk,
	input wire rst,
	input wire led_panel_pkg::bus_wr_t bus,
	input wire [$clog2(ROWS)-1:0] row_addr,
	input wire [$clog2(COLUMNS)-1:0] col_addr,
	input wire display_oe,
	input wire latch,
	input wire display_clk,
	input wire led_panel_pkg::pixel_t dout_a,
	input wire led_panel_pkg::pixel_t dout_b,
	output int error_count,
	output int check_count
);

	localparam int ROW_W = $clog2(ROWS);
	localparam int COL_W = $clog2(COLUMNS);

	led_panel_pkg::pixel_t shadow [2][ROWS][COLUMNS]; // [half][row][col]
	logic [15:0] shadow_blank;
	logic shadow_en;

	int exp_row;
	int exp_col; // also the clock pulse count of the row
	int oe_run;
	int blank_len;
	logic after_latch;
	logic stopped; // scan parked before column 0

	initial begin
		error_count = 0;
		check_count = 0;
		for (int h = 0; h < 2; h++) begin
			for (int r = 0; r < ROWS; r++) begin
				for (int c = 0; c < COLUMNS; c++) begin
					shadow[h][r][c] = '0;
				end
			end
		end
	end

	// upper half in the high byte nibble, lower half below it
	function automatic logic [7:0] expected_pixels(input int row, input int col);
		return {shadow[0][row][col], shadow[1][row][col]};
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		if (expected !== actual) begin
			error_count++;
			$display("[ERROR] %s: expected 0x%h, got 0x%h at time %0t", name, expected,
				actual, $time);
		end
	endtask

	task automatic report_failure(input string what);
		error_count++;
		$display("scan check failed: %s at time %0t", what, $time);
	endtask

	// mirrors the store decode of the frame store and the timing registers
	task automatic apply_store(input led_panel_pkg::bus_wr_t b);
		int half;
		int row;
		int col;
		if (b.strobe && (b.addr[31:16] == led_panel_pkg::FB_REGION)) begin
			half = b.addr[2 + COL_W + ROW_W];
			row = b.addr[2 + COL_W +: ROW_W];
			col = b.addr[2 +: COL_W];
			shadow[half][row][col] = b.data[3:0];
		end else if (b.strobe && (b.addr[31:16] == led_panel_pkg::CTRL_REGION)) begin
			if (b.addr[15:2] == led_panel_pkg::BLANK_REG_WORD) begin
				if (b.data[15:0] != 16'd0) begin
					shadow_blank = b.data[15:0]; // zero is refused
				end
			end else if (b.addr[15:2] == led_panel_pkg::ENABLE_REG_WORD) begin
				shadow_en = b.data[0];
			end
		end
	endtask

	always @(negedge clk) begin
		if (rst) begin
			check_value("display_oe", 1, display_oe);
			check_value("latch", 0, latch);
			check_value("display_clk", 0, display_clk);
			check_value("dout_a", 0, dout_a);
			check_value("dout_b", 0, dout_b);
			check_value("row_addr", 0, row_addr);
			check_value("col_addr", 0, col_addr);
			shadow_blank = 16'(BLANK_RESET);
			shadow_en = 1'b1;
			exp_row = 0;
			exp_col = 0;
			oe_run = 0;
			blank_len = BLANK_RESET;
			after_latch = 1'b0;
			stopped = 1'b0;
		end else begin
			if (display_clk) begin
				if (stopped) begin
					report_failure("display_clk pulse while scanning is disabled");
				end
				check_value("col_addr", exp_col, col_addr);
				check_value("row_addr", exp_row, row_addr);
				check_value("dout_a", expected_pixels(exp_row, exp_col) >> 4, dout_a);
				check_value("dout_b", expected_pixels(exp_row, exp_col) & 8'h0f, dout_b);
				exp_col++;
			end
			if (latch) begin
				check_value("display_clk pulses per row", COLUMNS, exp_col);
				check_value("row_addr", exp_row, row_addr);
				exp_row = (exp_row + 1) % ROWS;
				exp_col = 0;
			end
			if (after_latch) begin
				blank_len = shadow_blank; // taken as blanking starts
			end
			after_latch = latch;
			if (!display_oe) begin
				if (stopped) begin
					report_failure("display_oe low while scanning is disabled");
				end
				oe_run++;
				if (oe_run == blank_len) begin
					stopped = !shadow_en; // enable seen at the row boundary
				end
			end else if (oe_run != 0) begin
				check_value("display_oe low length", blank_len, oe_run);
				oe_run = 0;
			end
			if (stopped && shadow_en) begin
				stopped = 1'b0;
			end
			apply_store(bus);
		end
	end

endmodule

`default_nettype wire

// ==== bench/tb_led_panel.sv ====
`default_nettype none

module tb_led_panel;

	localparam int COLUMNS = led_panel_pkg::DEFAULT_COLUMNS;
	localparam int ROWS = led_panel_pkg::DEFAULT_ROWS;
	localparam int ROW_W = $clog2(ROWS);
	localparam int COL_W = $clog2(COLUMNS);
	localparam int NEW_BLANK = 20;
	localparam int LONGEST_ROW = COLUMNS * 3 + 2 + NEW_BLANK;
	// default rows, fill, frame, blank tests, stray stores, stop, resume frame
	localparam int PLANNED_ROWS = 2 + 2 + (ROWS + 1) + 3 + 3 + 3 + 2 + 4 + (ROWS + 1);
	localparam int WATCHDOG_CYCLES = PLANNED_ROWS * LONGEST_ROW + 2000;
	localparam logic [31:0] BLANK_ADDR = {led_panel_pkg::CTRL_REGION, 16'h0000};
	localparam logic [31:0] ENABLE_ADDR = {led_panel_pkg::CTRL_REGION, 16'h0004};

	logic clk;
	logic rst;
	led_panel_pkg::bus_wr_t bus;
	logic [ROW_W-1:0] row_addr;
	logic [COL_W-1:0] col_addr;
	logic display_oe;
	logic latch;
	logic display_clk;
	led_panel_pkg::pixel_t dout_a;
	led_panel_pkg::pixel_t dout_b;
	int error_count;
	int check_count;
	logic [31:0] lfsr_state;

	led_panel_top dut0 (
		.clk(clk),
		.rst(rst),
		.bus(bus),
		.row_addr(row_addr),
		.col_addr(col_addr),
		.display_oe(display_oe),
		.latch(latch),
		.display_clk(display_clk),
		.dout_a(dout_a),
		.dout_b(dout_b)
	);

	panel_monitor #(
		.COLUMNS(COLUMNS),
		.ROWS(ROWS),
		.BLANK_RESET(led_panel_pkg::DEFAULT_BLANK)
	) monitor0 (
		.clk(clk),
		.rst(rst),
		.bus(bus),
		.row_addr(row_addr),
		.col_addr(col_addr),
		.display_oe(display_oe),
		.latch(latch),
		.display_clk(display_clk),
		.dout_a(dout_a),
		.dout_b(dout_b),
		.error_count(error_count),
		.check_count(check_count)
	);

	initial begin
		clk = 1'b0;
	end

	always #50 clk = ~clk;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	task automatic step();
		@(posedge clk);
		#10;
	endtask

	task automatic bus_store(input logic [31:0] addr, input logic [31:0] data);
		bus.addr = addr;
		bus.data = data;
		bus.strobe = 1'b1;
		step();
		bus.strobe = 1'b0;
	endtask

	// returns inside the latch-high cycle
	task automatic wait_latch();
		do begin
			step();
		end while (!latch);
	endtask

	task automatic wait_rows(input int n);
		repeat (n) wait_latch();
	endtask

	task automatic fill_pixels(input int count, input logic avoid_scan_row);
		logic [31:0] half;
		logic [31:0] row;
		logic [31:0] col;
		logic [31:0] data;
		logic [31:0] addr;
		for (int n = 0; n < count; n++) begin
			draw_bits(1, half);
			draw_bits(ROW_W, row);
			draw_bits(COL_W, col);
			draw_bits(32, data);
			if (avoid_scan_row && (row == 32'(row_addr))) begin
				row = row ^ 32'd1; // keep clear of the row being fetched
			end
			addr = {led_panel_pkg::FB_REGION, 16'h0000} | (half << (2 + COL_W + ROW_W))
				| (row << (2 + COL_W)) | (col << 2);
			bus_store(addr, data);
			step();
		end
	endtask

	task automatic stray_stores(input int count);
		logic [31:0] low;
		logic [31:0] data;
		for (int n = 0; n < count; n++) begin
			draw_bits(16, low);
			draw_bits(32, data);
			bus_store({16'h0001, low[15:0]}, data);
		end
		bus_store({led_panel_pkg::CTRL_REGION, 16'h0008}, 32'd1); // unused ctrl word
	endtask

	initial begin
		rst = 1'b1;
		bus = '0;
		lfsr_state = 32'h4301;
		repeat (10) @(posedge clk);
		#10;
		rst = 1'b0;
		wait_rows(2); // empty frame, reset blanking
		fill_pixels(200, 1'b1);
		wait_rows(ROWS + 1);
		bus_store(BLANK_ADDR, NEW_BLANK);
		wait_rows(3);
		bus_store(BLANK_ADDR, 32'd0); // refused, length stays
		wait_rows(3);
		stray_stores(16);
		wait_rows(2);
		// park the scan at the end of this row
		wait_latch();
		bus_store(ENABLE_ADDR, 32'd0);
		do begin
			step();
		end while (display_oe);
		do begin
			step();
		end while (!display_oe);
		repeat (3 * LONGEST_ROW) step();
		fill_pixels(32, 1'b0);
		bus_store(ENABLE_ADDR, 32'd1);
		wait_rows(ROWS + 1);
		step(); // monitor still has to see the last latch
		$display("errors: %0d, checks: %0d", error_count, check_count);
		if ((error_count == 0) && (check_count > 0)) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: test sequence did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("errors: %0d, checks: %0d", error_count, check_count);
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
hdl/led_panel_pkg.sv
hdl/frame_store.sv
hdl/scan_timing_regs.sv
hdl/scan_ctrl.sv
hdl/led_panel_top.sv
bench/panel_monitor.sv
bench/tb_led_panel.sv
